// File: Makefile
VERILATOR = verilator
LINT_FLAGS = --lint-only --timing
SIM_FLAGS = --binary --timing
TOP = tb_sprite_engine
RTL_TOP = sprite_engine
FILELIST = list.f
OBJ_DIR = obj_dir
PASS_MSG = Simulation PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: line_buffer.sv
`timescale 1ns/1ps

module line_buffer
	import sprite_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      line_start,
	input  lb_write_t lb_wr,
	input  pos_t      hcnt,
	input  logic      pix_ce,
	output pixel_t    pixel_out
);

	// Two slots of 512 entries, slot number is the top address bit
	colour_t mem [0:1023];
	// Slot being drawn into, the other one is played out
	logic slot_wr;
	pos_t rd_x;
	colour_t rd_data;

	// Line buffer X is offset by the left border
	assign rd_x = hcnt + pos_t'(BORDER);
	assign rd_data = mem[{~slot_wr, rd_x}];

	// Drawer writes and readout clears always hit different slots
	always_ff @(posedge clk)
	begin
		if (lb_wr.we)
		begin
			mem[{slot_wr, lb_wr.x}] <= lb_wr.colour;
		end
		if (pix_ce)
		begin
			mem[{~slot_wr, rd_x}] <= '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			slot_wr <= 1'b1;
			pixel_out <= '0;
		end
		else
		begin
			if (line_start)
				slot_wr <= ~slot_wr;
			// Widen each 5-bit channel by repeating its top bits
			if (pix_ce)
			begin
				pixel_out.r <= {rd_data[4:0], rd_data[4:2]};
				pixel_out.g <= {rd_data[9:5], rd_data[9:7]};
				pixel_out.b <= {rd_data[14:10], rd_data[14:12]};
				pixel_out.a <= rd_data[15];
			end
		end
	end

endmodule

// File: list.f
sprite_pkg.sv
sprite_scanner.sv
sprite_drawer.sv
line_buffer.sv
sprite_engine.sv
tb_sprite_engine.sv

// File: sprite_drawer.sv
`timescale 1ns/1ps

module sprite_drawer
	import sprite_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         draw_req,
	input  sprite_draw_t draw,
	input  logic [7:0]   sprom_data,
	input  colour_t      pal_data,
	output logic         draw_ack,
	output sprom_addr_t  sprom_addr,
	output pal_addr_t    pal_addr,
	output lb_write_t    lb_wr
);

	draw_state_t state;
	logic [5:0] side;
	// Pixel count along the row, also the line buffer X offset
	logic [5:0] col;
	sprom_addr_t row_base;
	sprom_addr_t first_col;

	assign side = side_of(draw.size);

	// Start of the image row: base + image*side*side + row*side
	always_comb
	begin
		case (draw.size)
			SIZE_32:
				row_base = ROM_BASE_32 + {draw.image, 10'b0}
					+ sprom_addr_t'({draw.row, 5'b0});
			SIZE_16:
				row_base = ROM_BASE_16 + sprom_addr_t'({draw.image, 8'b0})
					+ sprom_addr_t'({draw.row[3:0], 4'b0});
			SIZE_8:
				row_base = ROM_BASE_8 + sprom_addr_t'({draw.image, 6'b0})
					+ sprom_addr_t'({draw.row[2:0], 3'b0});
			default:
				row_base = '0;
		endcase
	end

	// Mirrored rows are read from the last column backwards
	assign first_col = draw.mirror ? sprom_addr_t'(side - 6'd1) : '0;

	always_ff @(posedge clk)
	begin
		lb_wr.we <= 1'b0;
		if (reset)
		begin
			state <= DR_IDLE;
			draw_ack <= 1'b0;
		end
		else
		begin
			case (state)
				DR_IDLE:
				begin
					if (draw_req)
					begin
						sprom_addr <= row_base + first_col;
						col <= '0;
						state <= DR_ROM_WAIT;
					end
				end
				DR_ROM_WAIT:
				begin
					state <= DR_PAL;
				end
				DR_PAL:
				begin
					// Low 5 bits of the image byte pick the colour in the palette
					pal_addr <= {draw.palette, sprom_data[4:0], 1'b0};
					if (draw.mirror)
						sprom_addr <= sprom_addr - 17'd1;
					else
						sprom_addr <= sprom_addr + 17'd1;
					state <= DR_PAL_WAIT;
				end
				DR_PAL_WAIT:
				begin
					state <= DR_WRITE;
				end
				DR_WRITE:
				begin
					// Transparent entries leave whatever is already there
					lb_wr.we <= pal_data[15];
					lb_wr.x <= draw.x + pos_t'(col);
					lb_wr.colour <= pal_data;
					if (col == side - 6'd1)
					begin
						state <= DR_DONE;
					end
					else
					begin
						col <= col + 6'd1;
						state <= DR_PAL;
					end
				end
				DR_DONE:
				begin
					// Last pixel lands on this edge
					draw_ack <= 1'b1;
					state <= DR_ACK;
				end
				DR_ACK:
				begin
					if (!draw_req)
					begin
						draw_ack <= 1'b0;
						state <= DR_IDLE;
					end
				end
				default:
				begin
					state <= DR_IDLE;
				end
			endcase
		end
	end

endmodule

// File: sprite_engine.sv
`timescale 1ns/1ps

module sprite_engine
	import sprite_pkg::*;
#(
	// Number of sprite RAM entries walked per line
	parameter int SPRITE_COUNT_USED = SPRITE_COUNT
)(
	input  logic        clk,
	input  logic        reset,
	input  logic        hsync,
	input  pos_t        vcnt,
	input  pos_t        hcnt,
	input  logic        pix_ce,
	input  logic [7:0]  spram_data,
	input  logic [7:0]  sprom_data,
	input  colour_t     pal_data,
	output spram_addr_t spram_addr,
	output sprom_addr_t sprom_addr,
	output pal_addr_t   pal_addr,
	output pixel_t      pixel_out,
	output logic        busy
);

	// Scanner to drawer handshake
	sprite_draw_t draw;
	logic draw_req;
	logic draw_ack;
	// Slot swap pulse and drawer writes into the line buffer
	logic line_start;
	lb_write_t lb_wr;

	sprite_scanner #(
		.SPRITE_COUNT_USED(SPRITE_COUNT_USED)
	) scanner0 (
		.clk(clk),
		.reset(reset),
		.hsync(hsync),
		.vcnt(vcnt),
		.spram_data(spram_data),
		.draw_ack(draw_ack),
		.spram_addr(spram_addr),
		.draw_req(draw_req),
		.draw(draw),
		.line_start(line_start),
		.busy(busy)
	);

	sprite_drawer drawer0 (
		.clk(clk),
		.reset(reset),
		.draw_req(draw_req),
		.draw(draw),
		.sprom_data(sprom_data),
		.pal_data(pal_data),
		.draw_ack(draw_ack),
		.sprom_addr(sprom_addr),
		.pal_addr(pal_addr),
		.lb_wr(lb_wr)
	);

	line_buffer line_buffer0 (
		.clk(clk),
		.reset(reset),
		.line_start(line_start),
		.lb_wr(lb_wr),
		.hcnt(hcnt),
		.pix_ce(pix_ce),
		.pixel_out(pixel_out)
	);

endmodule

// File: sprite_pkg.sv
package sprite_pkg;

	// Screen or line buffer position, X or Y
	typedef logic [8:0] pos_t;
	typedef logic [4:0] sprite_index_t;
	// Sprite RAM address is index*4 plus byte number
	typedef logic [6:0] spram_addr_t;
	typedef logic [16:0] sprom_addr_t;
	typedef logic [7:0] pal_addr_t;
	// Palette entry: alpha, then 5 bits each of blue, green, red
	typedef logic [15:0] colour_t;
	typedef logic [1:0] size_code_t;

	// Scan constants
	localparam int SPRITE_COUNT = 32;
	localparam int SPRAM_ITEM_BYTES = 4;
	localparam int BORDER = 32;
	localparam int LAST_LINE = 255;

	// Image base address in sprite ROM for each sprite size
	localparam sprom_addr_t ROM_BASE_32 = 17'd0;
	localparam sprom_addr_t ROM_BASE_16 = 17'd4096;
	localparam sprom_addr_t ROM_BASE_8 = 17'd8192;

	// Size field codes, code 3 means the sprite is not drawn
	localparam size_code_t SIZE_32 = 2'd0;
	localparam size_code_t SIZE_16 = 2'd1;
	localparam size_code_t SIZE_8 = 2'd2;
	localparam size_code_t SIZE_NONE = 2'd3;

	// One sprite row handed from scanner to drawer
	typedef struct packed {
		pos_t x;
		logic [4:0] row;
		logic [6:0] image;
		logic [1:0] palette;
		size_code_t size;
		logic mirror;
	} sprite_draw_t;

	// Line buffer write port
	typedef struct packed {
		logic we;
		pos_t x;
		colour_t colour;
	} lb_write_t;

	// Expanded output pixel
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic a;
	} pixel_t;

	typedef enum logic [3:0] {
		SC_IDLE,
		SC_WAIT0,
		SC_BYTE0,
		SC_BYTE1,
		SC_CHECK,
		SC_BYTE2,
		SC_BYTE3,
		SC_REQ,
		SC_RELEASE,
		SC_NEXT
	} scan_state_t;

	typedef enum logic [2:0] {
		DR_IDLE,
		DR_ROM_WAIT,
		DR_PAL,
		DR_PAL_WAIT,
		DR_WRITE,
		DR_DONE,
		DR_ACK
	} draw_state_t;

	// Sprite side length in pixels, zero for the undrawn code
	function automatic logic [5:0] side_of(input size_code_t size);
		case (size)
			SIZE_32: return 6'd32;
			SIZE_16: return 6'd16;
			SIZE_8: return 6'd8;
			default: return 6'd0;
		endcase
	endfunction

endpackage

// File: sprite_scanner.sv
`timescale 1ns/1ps

module sprite_scanner
	import sprite_pkg::*;
#(
	parameter int SPRITE_COUNT_USED = SPRITE_COUNT
)(
	input  logic         clk,
	input  logic         reset,
	input  logic         hsync,
	input  pos_t         vcnt,
	input  logic [7:0]   spram_data,
	input  logic         draw_ack,
	output spram_addr_t  spram_addr,
	output logic         draw_req,
	output sprite_draw_t draw,
	output logic         line_start,
	output logic         busy
);

	scan_state_t state;
	logic hsync_last;
	// Line being built, in line buffer coordinates
	pos_t active_y;
	// Top line and enable of the entry under test
	pos_t y;
	logic enable;
	sprite_index_t index;
	logic [9:0] y_diff;
	logic covered;

	// Rows below the sprite top, wraps to a large value when above it
	assign y_diff = {1'b0, active_y} - {1'b0, y};
	// Enabled, drawable size, and within side rows of the top
	assign covered = enable && (draw.size != SIZE_NONE)
		&& (y_diff < 10'(side_of(draw.size)));
	assign busy = (state != SC_IDLE);

	always_ff @(posedge clk)
	begin
		hsync_last <= hsync;
		line_start <= 1'b0;
		if (reset)
		begin
			state <= SC_IDLE;
			draw_req <= 1'b0;
			line_start <= 1'b0;
			hsync_last <= 1'b0;
		end
		else
		begin
			case (state)
				SC_IDLE:
				begin
					// New line on hsync rise, rises during a scan never get here
					if (hsync && !hsync_last)
					begin
						line_start <= 1'b1;
						if (vcnt == pos_t'(LAST_LINE))
							active_y <= pos_t'(BORDER);
						else
							active_y <= vcnt + pos_t'(BORDER + 1);
						index <= '0;
						spram_addr <= '0;
						state <= SC_WAIT0;
					end
				end
				SC_WAIT0:
				begin
					// Byte 0 address is sampled now, queue byte 1 behind it
					spram_addr <= spram_addr + 7'd1;
					state <= SC_BYTE0;
				end
				SC_BYTE0:
				begin
					// Bit 6 is the collide flag, not used here
					enable <= spram_data[7];
					draw.palette <= spram_data[5:4];
					draw.size <= spram_data[3:2];
					draw.mirror <= spram_data[1];
					y[8] <= spram_data[0];
					state <= SC_BYTE1;
				end
				SC_BYTE1:
				begin
					y[7:0] <= spram_data;
					spram_addr <= spram_addr + 7'd1;
					state <= SC_CHECK;
				end
				SC_CHECK:
				begin
					// Byte 2 is sampled on this edge whether or not it is used
					if (covered)
					begin
						spram_addr <= spram_addr + 7'd1;
						state <= SC_BYTE2;
					end
					else
					begin
						state <= SC_NEXT;
					end
				end
				SC_BYTE2:
				begin
					draw.image <= spram_data[7:1];
					draw.x[8] <= spram_data[0];
					state <= SC_BYTE3;
				end
				SC_BYTE3:
				begin
					draw.x[7:0] <= spram_data;
					draw.row <= y_diff[4:0];
					draw_req <= 1'b1;
					state <= SC_REQ;
				end
				SC_REQ:
				begin
					// Descriptor holds still until the drawer finishes the row
					if (draw_ack)
					begin
						draw_req <= 1'b0;
						state <= SC_RELEASE;
					end
				end
				SC_RELEASE:
				begin
					if (!draw_ack)
						state <= SC_NEXT;
				end
				SC_NEXT:
				begin
					if (index == sprite_index_t'(SPRITE_COUNT_USED - 1))
					begin
						state <= SC_IDLE;
					end
					else
					begin
						index <= index + 5'd1;
						spram_addr <= spram_addr_t'((index + 5'd1) * SPRAM_ITEM_BYTES);
						state <= SC_WAIT0;
					end
				end
				default:
				begin
					state <= SC_IDLE;
				end
			endcase
		end
	end

endmodule

// File: tb_sprite_engine.sv
`timescale 1ns/1ps

module tb_sprite_engine
	import sprite_pkg::*;
();

	// Cycles allowed for one full line scan
	localparam int SCAN_TIMEOUT = 20000;

	logic clk;
	logic reset;
	logic hsync;
	pos_t vcnt;
	pos_t hcnt;
	logic pix_ce;
	logic [7:0] spram_data = 8'h00;
	logic [7:0] sprom_data = 8'h00;
	colour_t pal_data = 16'h0000;
	spram_addr_t spram_addr;
	sprom_addr_t sprom_addr;
	pal_addr_t pal_addr;
	pixel_t pixel_out;
	logic busy;

	// External memory contents
	logic [7:0] spram [0:127];
	logic [7:0] sprom [0:131071];
	colour_t pal [0:255];

	// Expected colours of the slot being played out
	colour_t exp_col [0:511];
	// Readout capture, one clock behind pix_ce
	logic compare_on;
	logic ce_q;
	pos_t x_q;

	sprite_engine #(
		.SPRITE_COUNT_USED(SPRITE_COUNT)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.hsync(hsync),
		.vcnt(vcnt),
		.hcnt(hcnt),
		.pix_ce(pix_ce),
		.spram_data(spram_data),
		.sprom_data(sprom_data),
		.pal_data(pal_data),
		.spram_addr(spram_addr),
		.sprom_addr(sprom_addr),
		.pal_addr(pal_addr),
		.pixel_out(pixel_out),
		.busy(busy)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Registered reads, data one clock after the address
	always @(posedge clk)
	begin
		spram_data <= spram[spram_addr];
		sprom_data <= sprom[sprom_addr];
		pal_data <= pal[pal_addr];
	end

	// Palette entry to 8-bit channels, top bits repeated below
	function automatic pixel_t widen_colour(input colour_t c);
		pixel_t p;
		p.r = {c[4:0], c[4:2]};
		p.g = {c[9:5], c[9:7]};
		p.b = {c[14:10], c[14:12]};
		p.a = c[15];
		return p;
	endfunction

	task automatic check_pixel(input pixel_t got, input pixel_t want, input pos_t x);
		if (got !== want)
		begin
			$display("Mismatch pixel_out at hcnt %h: got %h expected %h", x, got, want);
			$display("Simulation FAILED");
			$fatal(1, "pixel compare error");
		end
	endtask

	task automatic check_busy(input logic got, input logic want);
		if (got !== want)
		begin
			$display("Mismatch busy: got %h expected %h", got, want);
			$display("Simulation FAILED");
			$fatal(1, "busy compare error");
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout: %s", what);
		$display("Simulation FAILED");
		$fatal(1, "wait limit reached");
	endtask

	// Whole line built from sprite RAM, sprites in index order
	function automatic void expected_line(input pos_t v);
		pos_t ay;
		pos_t y;
		pos_t x;
		int side;
		int base;
		int row;
		int addr;
		int col;
		logic [7:0] b0;
		logic [7:0] pix;
		colour_t c;
		for (int i = 0; i < 512; i++)
			exp_col[9'(i)] = '0;
		// Last line wraps back to the top border
		ay = (v == pos_t'(LAST_LINE)) ? pos_t'(BORDER) : v + pos_t'(BORDER + 1);
		for (int i = 0; i < SPRITE_COUNT; i++)
		begin
			b0 = spram[7'(i * 4)];
			if (!b0[7] || b0[3:2] == SIZE_NONE)
				continue;
			// 32, 16 or 8 pixels per side
			side = 32 >> b0[3:2];
			y = {b0[0], spram[7'(i * 4 + 1)]};
			row = int'(ay) - int'(y);
			if (row < 0 || row >= side)
				continue;
			x = {spram[7'(i * 4 + 2)][0], spram[7'(i * 4 + 3)]};
			if (b0[3:2] == SIZE_32)
				base = int'(ROM_BASE_32);
			else if (b0[3:2] == SIZE_16)
				base = int'(ROM_BASE_16);
			else
				base = int'(ROM_BASE_8);
			addr = base + int'(spram[7'(i * 4 + 2)][7:1]) * side * side + row * side;
			for (int k = 0; k < side; k++)
			begin
				col = b0[1] ? side - 1 - k : k;
				pix = sprom[17'(addr + col)];
				c = pal[{b0[5:4], pix[4:0], 1'b0}];
				// Transparent entries keep the earlier sprite
				if (c[15])
					exp_col[x + 9'(k)] = c;
			end
		end
	endfunction

	task automatic fill_memories();
		for (int a = 0; a < 131072; a++)
			sprom[17'(a)] = 8'($urandom);
		// Alpha is random per palette entry
		for (int a = 0; a < 256; a++)
			pal[8'(a)] = 16'($urandom);
	endtask

	task automatic clear_sprites();
		for (int a = 0; a < 128; a++)
			spram[7'(a)] = 8'h00;
	endtask

	task automatic set_sprite(input int idx, input logic en, input logic [1:0] palette,
		input size_code_t size, input logic mirror, input pos_t y, input logic [6:0] image,
		input pos_t x);
		spram[7'(idx * 4)] = {en, 1'b0, palette, size, mirror, y[8]};
		spram[7'(idx * 4 + 1)] = y[7:0];
		spram[7'(idx * 4 + 2)] = {image, x[8]};
		spram[7'(idx * 4 + 3)] = x[7:0];
	endtask

	// Tops placed near the active line so most sprites hit it
	task automatic random_sprites(input pos_t v);
		pos_t ay;
		logic [7:0] b0;
		ay = (v == pos_t'(LAST_LINE)) ? pos_t'(BORDER) : v + pos_t'(BORDER + 1);
		for (int i = 0; i < SPRITE_COUNT; i++)
		begin
			b0 = 8'($urandom);
			set_sprite(i, ($urandom % 4) != 0, b0[5:4], b0[3:2], b0[1],
				ay - 9'($urandom % 40), 7'($urandom), 9'($urandom));
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy)
		begin
			@(posedge clk);
			#1;
			n++;
			if (n > SCAN_TIMEOUT)
				fail_timeout("busy did not fall after a line scan");
		end
	endtask

	// hsync rise, held until the scanner reports busy
	task automatic start_line(input pos_t v);
		int n;
		wait_idle();
		vcnt = v;
		hsync = 1'b1;
		n = 0;
		while (!busy)
		begin
			@(posedge clk);
			#1;
			n++;
			if (n > 8)
				fail_timeout("busy did not rise after hsync");
		end
		hsync = 1'b0;
	endtask

	// Sweep the visible width, pix_ce on every other cycle
	task automatic read_line(input logic compare);
		compare_on = compare;
		for (int h = 0; h < 320; h++)
		begin
			@(posedge clk);
			#1;
			hcnt = pos_t'(h);
			pix_ce = 1'b1;
			@(posedge clk);
			#1;
			pix_ce = 1'b0;
		end
		@(posedge clk);
		#1;
		compare_on = 1'b0;
	endtask

	// Draw one line, swap it to the read side and compare it
	task automatic run_line(input pos_t v);
		expected_line(v);
		start_line(v);
		start_line(v);
		read_line(1'b1);
	endtask

	always @(posedge clk)
	begin
		ce_q <= pix_ce && compare_on;
		x_q <= hcnt;
	end

	// Compare process, pixel_out is settled by the falling edge
	always @(negedge clk)
	begin
		if (ce_q)
			check_pixel(pixel_out, widen_colour(exp_col[x_q + pos_t'(BORDER)]), x_q);
	end

	initial
	begin
		void'($urandom(32'ha95b));
		reset = 1'b1;
		hsync = 1'b0;
		vcnt = '0;
		hcnt = '0;
		pix_ce = 1'b0;
		compare_on = 1'b0;
		fill_memories();
		clear_sprites();
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		check_busy(busy, 1'b0);
		check_pixel(pixel_out, '0, '0);
		// Slot 0 starts unknown, one readout zeroes it
		read_line(1'b0);

		// Single 8x8 sprite
		set_sprite(0, 1'b1, 2'd1, SIZE_8, 1'b0, 9'd130, 7'd5, 9'd100);
		run_line(9'd100);

		// Sizes 16 and 32, plain and mirrored
		clear_sprites();
		set_sprite(0, 1'b1, 2'd0, SIZE_16, 1'b0, 9'd120, 7'd17, 9'd200);
		set_sprite(1, 1'b1, 2'd2, SIZE_32, 1'b1, 9'd110, 7'd99, 9'd40);
		set_sprite(2, 1'b1, 2'd3, SIZE_8, 1'b1, 9'd128, 7'd127, 9'd300);
		set_sprite(3, 1'b1, 2'd1, SIZE_16, 1'b1, 9'd133, 7'd127, 9'd250);
		run_line(9'd100);

		// Overlap, higher index on top, see-through pixels
		clear_sprites();
		set_sprite(4, 1'b1, 2'd0, SIZE_32, 1'b0, 9'd105, 7'd3, 9'd60);
		set_sprite(9, 1'b1, 2'd3, SIZE_16, 1'b0, 9'd125, 7'd8, 9'd70);
		set_sprite(20, 1'b1, 2'd1, SIZE_32, 1'b1, 9'd102, 7'd64, 9'd80);
		run_line(9'd100);

		// Disabled, size code 3 and out of range lines
		clear_sprites();
		set_sprite(0, 1'b0, 2'd1, SIZE_16, 1'b0, 9'd130, 7'd2, 9'd100);
		set_sprite(1, 1'b1, 2'd2, SIZE_NONE, 1'b0, 9'd130, 7'd2, 9'd150);
		set_sprite(2, 1'b1, 2'd3, SIZE_8, 1'b0, 9'd200, 7'd2, 9'd200);
		set_sprite(3, 1'b1, 2'd0, SIZE_8, 1'b0, 9'd126, 7'd2, 9'd250);
		set_sprite(4, 1'b1, 2'd0, SIZE_8, 1'b0, 9'd125, 7'd4, 9'd270);
		run_line(9'd100);
		// Last line maps to the top border line
		clear_sprites();
		set_sprite(0, 1'b1, 2'd1, SIZE_8, 1'b0, 9'd25, 7'd6, 9'd120);
		set_sprite(1, 1'b1, 2'd2, SIZE_16, 1'b0, 9'd280, 7'd9, 9'd150);
		set_sprite(2, 1'b1, 2'd3, SIZE_32, 1'b1, 9'd33, 7'd1, 9'd180);
		run_line(9'(LAST_LINE));

		// Slot 0 again after two empty swaps reads all zero
		clear_sprites();
		start_line(9'd10);
		start_line(9'd10);
		for (int i = 0; i < 512; i++)
			exp_col[9'(i)] = '0;
		read_line(1'b1);

		// Random full lines over several vcnt values
		random_sprites(9'd0);
		run_line(9'd0);
		random_sprites(9'd37);
		run_line(9'd37);
		random_sprites(9'd128);
		run_line(9'd128);
		random_sprites(9'd200);
		run_line(9'd200);
		random_sprites(9'd254);
		run_line(9'd254);
		random_sprites(9'd255);
		run_line(9'd255);
		wait_idle();

		$display("Simulation PASSED");
		$finish;
	end

endmodule
